// File: files.f
+incdir+common
common/trace_pkg.sv
hw/trace_fifo/trace_fifo.sv
hw/retire_collector.sv
hw/trace_emitter.sv
hw/commit_tracer.sv
test/tb_commit_tracer.sv

// File: Bender.yml
package:
  name: commit_tracer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/trace_pkg.sv
      - hw/trace_fifo/trace_fifo.sv
      - hw/retire_collector.sv
      - hw/trace_emitter.sv
      - hw/commit_tracer.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_commit_tracer.sv

// File: test/tb_commit_tracer.sv
// testbench for the trace path top level; compile with files.f and run tb_commit_tracer as top
`timescale 1ns/1ps
`include "trace_macros.svh"

module tb_commit_tracer;

  localparam int NrPorts    = `TRACE_NR_COMMIT_PORTS;
  localparam int DrainLimit = 200;

  logic                                   clk;
  logic                                   rst_n;
  logic                     [NrPorts-1:0] commit_ack;
  trace_pkg::commit_entry_t [NrPorts-1:0] commit_entry;
  trace_pkg::priv_lvl_e                   priv_lvl;
  logic                                   debug_mode;
  logic                                   trace_valid;
  trace_pkg::trace_rec_t                  trace_rec;
  logic [`TRACE_CNT_W-1:0]                retired_cnt;
  logic [`TRACE_CNT_W-1:0]                exc_cnt;
  logic                                   overflow;

  // reference model state
  trace_pkg::trace_rec_t exp_q [$];
  logic [31:0]           rng_state;
  int unsigned           edge_cnt;
  int unsigned           exp_ret;
  int unsigned           exp_exc;
  int                    errors;
  int                    tests;
  logic                  seen_ack;
  logic                  allow_skip;
  logic                  check_latency;
  logic                  ovf_expected;
  logic                  use_debug;

  commit_tracer u_commit_tracer (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_ack_i   ( commit_ack   ),
    .commit_entry_i ( commit_entry ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .trace_valid_o  ( trace_valid  ),
    .trace_rec_o    ( trace_rec    ),
    .retired_cnt_o  ( retired_cnt  ),
    .exc_cnt_o      ( exc_cnt      ),
    .overflow_o     ( overflow     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // rising edges since reset release, same count the collector stamps with
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic trace_pkg::trace_mode_e expected_mode(input logic [1:0] priv,
                                                          input logic dbg);
    if (dbg) begin
      return trace_pkg::MODE_D;
    end
    case (priv)
      2'd3:    return trace_pkg::MODE_M;
      2'd1:    return trace_pkg::MODE_S;
      default: return trace_pkg::MODE_U;
    endcase
  endfunction

  // --------------------------------------------------
  // output checking
  // --------------------------------------------------
  always @(negedge clk) begin : check_output
    trace_pkg::trace_rec_t want;
    if (rst_n && trace_valid) begin
      // dropped records never show up, so pass over them
      if (allow_skip) begin
        while (exp_q.size() > 0 && exp_q[0] !== trace_rec) begin
          void'(exp_q.pop_front());
        end
      end
      if (exp_q.size() == 0) begin
        $display("** Error at %0t: record pc=%h emitted but none expected", $time, trace_rec.pc);
        errors++;
      end else begin
        want = exp_q.pop_front();
        assert (trace_rec === want) else begin
          $display("** Error at %0t: got pc=%h stamp=%0d mode=%0d exc=%b cause=%0d", $time,
                   trace_rec.pc, trace_rec.stamp, trace_rec.mode, trace_rec.is_exc,
                   trace_rec.cause);
          $display("** Error at %0t: want pc=%h stamp=%0d mode=%0d exc=%b cause=%0d", $time,
                   want.pc, want.stamp, want.mode, want.is_exc, want.cause);
          errors++;
        end
        // sampled at edge stamp, emitted after two more edges
        if (check_latency) begin
          assert (edge_cnt == want.stamp + 3) else begin
            $display("** Error at %0t: record stamp %0d arrived at edge %0d", $time,
                     want.stamp, edge_cnt);
            errors++;
          end
        end
        if (want.is_exc) begin
          exp_exc++;
        end else begin
          exp_ret++;
        end
      end
    end
  end

  a_quiet_before_ack : assert property (
    @(posedge clk) disable iff (!rst_n)
    !seen_ack |-> (!trace_valid && !overflow && retired_cnt == '0 && exc_cnt == '0)
  ) else begin
    $display("** Error at %0t: output active before any acknowledgement", $time);
    errors++;
  end

  a_overflow_sticky : assert property (
    @(posedge clk) disable iff (!rst_n) overflow |=> overflow
  ) else begin
    $display("** Error at %0t: overflow flag dropped after it was raised", $time);
    errors++;
  end

  a_no_early_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) !ovf_expected |-> !overflow
  ) else begin
    $display("** Error at %0t: overflow raised without a burst", $time);
    errors++;
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  // called at a falling edge, returns at the next one
  task automatic commit_cycle(input logic [1:0] ack, input logic [1:0] exc,
                              input logic rand_cause);
    trace_pkg::trace_rec_t     rec;
    logic [31:0]               r;
    logic [1:0]                priv;
    logic                      dbg;
    logic [`TRACE_CAUSE_W-1:0] cause;
    r = next_rand();
    case (r % 3)
      0:       priv = 2'd0;
      1:       priv = 2'd1;
      default: priv = 2'd3;
    endcase
    dbg        = use_debug & r[8];
    priv_lvl   = trace_pkg::priv_lvl_e'(priv);
    debug_mode = dbg;
    for (int p = 0; p < NrPorts; p++) begin
      cause = '0;
      if (exc[p]) begin
        cause = rand_cause ? (next_rand() % 63) + 1 : `TRACE_CAUSE_ILLEGAL;
      end
      commit_entry[p].pc       = {next_rand(), next_rand()};
      commit_entry[p].tval     = next_rand();
      commit_entry[p].ex_valid = exc[p];
      commit_entry[p].cause    = cause;
    end
    commit_ack = ack;
    if (ack != '0) begin
      seen_ack = 1'b1;
    end
    // port 0 first, both share this edge's stamp
    for (int p = 0; p < NrPorts; p++) begin
      if (ack[p]) begin
        rec.stamp  = edge_cnt;
        rec.pc     = commit_entry[p].pc;
        rec.tval   = commit_entry[p].tval;
        rec.mode   = expected_mode(priv, dbg);
        rec.is_exc = exc[p];
        rec.cause  = commit_entry[p].cause;
        exp_q.push_back(rec);
      end
    end
    @(negedge clk);
  endtask

  task automatic wait_drained();
    int quiet;
    int waited;
    quiet      = 0;
    waited     = 0;
    commit_ack = '0;
    while (quiet < 4 && waited < DrainLimit) begin
      @(negedge clk);
      waited++;
      quiet = trace_valid ? 0 : quiet + 1;
    end
    if (quiet < 4) begin
      $display("trace output never went idle within %0d cycles", DrainLimit);
      errors++;
    end
  endtask

  task automatic check_counters();
    assert (retired_cnt == exp_ret && exc_cnt == exp_exc) else begin
      $display("** Error at %0t: counters retired=%0d exc=%0d, want %0d and %0d", $time,
               retired_cnt, exc_cnt, exp_ret, exp_exc);
      errors++;
    end
  endtask

  task automatic check_queue_empty();
    assert (exp_q.size() == 0) else begin
      $display("** Error at %0t: %0d expected records never emitted", $time, exp_q.size());
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_before);
    end
  endtask

  initial begin
    int          err_before;
    int unsigned pushed;
    int unsigned emitted;
    logic [31:0] r;
    rng_state     = 32'hcc15_0e24;
    errors        = 0;
    tests         = 0;
    exp_ret       = 0;
    exp_exc       = 0;
    seen_ack      = 1'b0;
    allow_skip    = 1'b0;
    check_latency = 1'b0;
    ovf_expected  = 1'b0;
    use_debug     = 1'b0;
    rst_n         = 1'b0;
    commit_ack    = '0;
    commit_entry  = '0;
    priv_lvl      = trace_pkg::PRIV_M;
    debug_mode    = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    err_before = errors;
    repeat (4) @(negedge clk);
    assert (!trace_valid && !overflow && retired_cnt == '0 && exc_cnt == '0) else begin
      $display("** Error at %0t: outputs not cleared after reset", $time);
      errors++;
    end
    report_test("reset state", err_before);

    err_before    = errors;
    check_latency = 1'b1;
    use_debug     = 1'b1;
    for (int i = 0; i < 24; i++) begin
      commit_cycle((i % 3 == 0) ? 2'b01 : (i % 3 == 1) ? 2'b10 : 2'b00, 2'b00, 1'b0);
    end
    wait_drained();
    check_latency = 1'b0;
    check_queue_empty();
    check_counters();
    report_test("single port", err_before);

    // one idle cycle after each pair keeps the fifo from filling
    err_before = errors;
    for (int i = 0; i < 10; i++) begin
      commit_cycle(2'b11, 2'b00, 1'b0);
      commit_cycle(2'b00, 2'b00, 1'b0);
    end
    wait_drained();
    check_queue_empty();
    check_counters();
    report_test("dual port order", err_before);

    err_before = errors;
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      commit_cycle((r[1:0] == 2'b00) ? 2'b11 : r[1:0], r[3:2], r[4]);
      commit_cycle(2'b00, 2'b00, 1'b0);
    end
    wait_drained();
    check_queue_empty();
    check_counters();
    report_test("exceptions and counters", err_before);

    err_before   = errors;
    allow_skip   = 1'b1;
    ovf_expected = 1'b1;
    emitted      = exp_ret + exp_exc;
    for (int i = 0; i < 16; i++) begin
      commit_cycle(2'b11, 2'b00, 1'b0);
    end
    pushed = 32;
    wait_drained();
    emitted = exp_ret + exp_exc - emitted;
    assert (overflow && emitted < pushed) else begin
      $display("** Error at %0t: burst gave overflow=%b with %0d of %0d emitted", $time,
               overflow, emitted, pushed);
      errors++;
    end
    exp_q.delete();
    check_counters();
    report_test("overflow", err_before);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hw/commit_tracer.sv
// retired-instruction trace path top level; connect to the commit ports and read trace_rec_o
`timescale 1ns/1ps
`include "trace_macros.svh"

module commit_tracer (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // commit side
  input  logic               [`TRACE_NR_COMMIT_PORTS-1:0]      commit_ack_i,
  input  trace_pkg::commit_entry_t [`TRACE_NR_COMMIT_PORTS-1:0] commit_entry_i,
  input  trace_pkg::priv_lvl_e                                 priv_lvl_i,
  input  logic                                                 debug_mode_i,
  // trace side
  output logic                                                 trace_valid_o,
  output trace_pkg::trace_rec_t                                trace_rec_o,
  output logic               [`TRACE_CNT_W-1:0]                retired_cnt_o,
  output logic               [`TRACE_CNT_W-1:0]                exc_cnt_o,
  output logic                                                 overflow_o
);

  // collector -> fifo
  logic                  [`TRACE_NR_COMMIT_PORTS-1:0] wr_valid;
  trace_pkg::trace_rec_t [`TRACE_NR_COMMIT_PORTS-1:0] wr_rec;

  // fifo <-> emitter
  logic                  rd_valid;
  trace_pkg::trace_rec_t rd_rec;
  logic                  rd_pop;

  retire_collector u_retire_collector (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_entry_i ( commit_entry_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .wr_valid_o     ( wr_valid       ),
    .wr_rec_o       ( wr_rec         )
  );

  trace_fifo #(
    .payload_t  ( trace_pkg::trace_rec_t )
  ) u_trace_fifo (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .wr_valid_i ( wr_valid   ),
    .wr_data_i  ( wr_rec     ),
    .rd_pop_i   ( rd_pop     ),
    .rd_valid_o ( rd_valid   ),
    .rd_data_o  ( rd_rec     ),
    .overflow_o ( overflow_o )
  );

  trace_emitter u_trace_emitter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .rd_valid_i    ( rd_valid      ),
    .rd_rec_i      ( rd_rec        ),
    .rd_pop_o      ( rd_pop        ),
    .trace_valid_o ( trace_valid_o ),
    .trace_rec_o   ( trace_rec_o   ),
    .retired_cnt_o ( retired_cnt_o ),
    .exc_cnt_o     ( exc_cnt_o     )
  );

endmodule

// File: hw/trace_emitter.sv
// drains one record per cycle onto the registered trace output and keeps the event counters
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_emitter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_valid_i,
  input  trace_pkg::trace_rec_t         rd_rec_i,
  output logic                          rd_pop_o,
  output logic                          trace_valid_o,
  output trace_pkg::trace_rec_t         trace_rec_o,
  output logic [`TRACE_CNT_W-1:0]       retired_cnt_o,
  output logic [`TRACE_CNT_W-1:0]       exc_cnt_o
);

  // no back-pressure on this path, take the head as soon as it shows up
  assign rd_pop_o = rd_valid_i;

  // --------------------------------------------------
  // output stage and counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_o <= 1'b0;
      retired_cnt_o <= '0;
      exc_cnt_o     <= '0;
    end else begin
      trace_valid_o <= rd_pop_o;
      if (rd_pop_o) begin
        if (rd_rec_i.is_exc) begin
          exc_cnt_o <= exc_cnt_o + 1'b1;
        end else begin
          retired_cnt_o <= retired_cnt_o + 1'b1;
        end
      end
    end
  end

  // payload only moves with a pop
  always_ff @(posedge clk_i) begin
    if (rd_pop_o) begin
      trace_rec_o <= rd_rec_i;
    end
  end

  // every emitted record was written by the collector in full
  a_rec_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) trace_valid_o |-> !$isunknown(trace_rec_o)
  ) else $error("trace record has unknown bits while valid");

endmodule

// File: hw/retire_collector.sv
// turns commit acknowledgements into cycle-stamped, mode-tagged trace records, one per port
`timescale 1ns/1ps
`include "trace_macros.svh"

module retire_collector (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic               [`TRACE_NR_COMMIT_PORTS-1:0]      commit_ack_i,
  input  trace_pkg::commit_entry_t [`TRACE_NR_COMMIT_PORTS-1:0] commit_entry_i,
  input  trace_pkg::priv_lvl_e                                 priv_lvl_i,
  input  logic                                                 debug_mode_i,
  output logic               [`TRACE_NR_COMMIT_PORTS-1:0]      wr_valid_o,
  output trace_pkg::trace_rec_t [`TRACE_NR_COMMIT_PORTS-1:0]   wr_rec_o
);

  logic [`TRACE_STAMP_W-1:0]  stamp_q;
  trace_pkg::trace_mode_e     mode;

  // --------------------------------------------------
  // cycle stamp
  // --------------------------------------------------
  // edges seen since reset release, sampled before the increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_q + 1'b1;
    end
  end

  // debug wins over the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        trace_pkg::PRIV_M: mode = trace_pkg::MODE_M;
        trace_pkg::PRIV_S: mode = trace_pkg::MODE_S;
        default:           mode = trace_pkg::MODE_U;
      endcase
    end
  end

  // --------------------------------------------------
  // record registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_o <= '0;
    end else begin
      wr_valid_o <= commit_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `TRACE_NR_COMMIT_PORTS; p++) begin
      if (commit_ack_i[p]) begin
        wr_rec_o[p].stamp  <= stamp_q;
        wr_rec_o[p].pc     <= commit_entry_i[p].pc;
        wr_rec_o[p].tval   <= commit_entry_i[p].tval;
        wr_rec_o[p].mode   <= mode;
        wr_rec_o[p].is_exc <= commit_entry_i[p].ex_valid;
        wr_rec_o[p].cause  <= commit_entry_i[p].cause;
      end
    end
  end

  // commit stage only reports a cause together with an exception
  for (genvar p = 0; p < `TRACE_NR_COMMIT_PORTS; p++) begin : g_cause_chk
    a_cause_needs_exc : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (commit_ack_i[p] && (commit_entry_i[p].cause != '0)) |-> commit_entry_i[p].ex_valid
    ) else $error("port %0d acknowledged with a cause but no exception", p);
  end

endmodule

// File: hw/trace_fifo/trace_fifo.sv
// circular record buffer with two in-order write ports and one read port; overflow drops and sticks
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // write side, port 0 ordered first
  input  logic     [`TRACE_NR_COMMIT_PORTS-1:0]    wr_valid_i,
  input  payload_t [`TRACE_NR_COMMIT_PORTS-1:0]    wr_data_i,
  // read side, level-valid head
  input  logic                                     rd_pop_i,
  output logic                                     rd_valid_o,
  output payload_t                                 rd_data_o,
  output logic                                     overflow_o
);

  localparam int unsigned Depth = `TRACE_FIFO_DEPTH;
  localparam int unsigned NrWr  = `TRACE_NR_COMMIT_PORTS;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic     [PtrW-1:0] rd_ptr_q, rd_ptr_d;
  logic     [PtrW-1:0] wr_ptr_q, wr_ptr_d;
  logic     [CntW-1:0] cnt_q, cnt_d;
  logic                pop;
  logic                drop;
  logic     [NrWr-1:0] wr_en;
  logic     [PtrW-1:0] wr_addr [NrWr];
  logic                ovf_q;

  assign rd_valid_o = (cnt_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign overflow_o = ovf_q;

  // head leaves before new records are placed
  assign pop = rd_pop_i & rd_valid_o;

  // --------------------------------------------------
  // slot allocation
  // --------------------------------------------------
  always_comb begin
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    cnt_d    = cnt_q;
    drop     = 1'b0;
    wr_en    = '0;
    if (pop) begin
      rd_ptr_d = rd_ptr_q + 1'b1;
      cnt_d    = cnt_q - 1'b1;
    end
    // later ports only see what earlier ports left
    for (int p = 0; p < NrWr; p++) begin
      wr_addr[p] = wr_ptr_d;
      if (wr_valid_i[p]) begin
        if (cnt_d < CntW'(Depth)) begin
          wr_en[p] = 1'b1;
          wr_ptr_d = wr_ptr_d + 1'b1;
          cnt_d    = cnt_d + 1'b1;
        end else begin
          drop = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      ovf_q    <= 1'b0;
    end else begin
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
      ovf_q    <= ovf_q | drop;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NrWr; p++) begin
      if (wr_en[p]) begin
        mem_q[wr_addr[p]] <= wr_data_i[p];
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // consumer must only pop a valid head
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) rd_pop_i |-> rd_valid_o
  ) else $error("pop while the trace fifo is empty");

  a_cnt_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni) cnt_q <= CntW'(Depth)
  ) else $error("trace fifo fill count above capacity");

endmodule

// File: common/trace_pkg.sv
// shared commit-entry, trace-record and mode types; referenced by scoped name from RTL and testbench
`include "trace_macros.svh"

package trace_pkg;

  // --------------------------------------------------
  // mode tags
  // --------------------------------------------------
  // mode letter attached to every trace record
  typedef enum logic [1:0] {
    MODE_U,
    MODE_S,
    MODE_M,
    MODE_D
  } trace_mode_e;

  // privilege level as driven by the CSR file
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------
  // one commit port entry, 103 bits
  typedef struct packed {
    logic [`TRACE_XLEN-1:0]    pc;
    logic [`TRACE_TVAL_W-1:0]  tval;
    logic                      ex_valid;
    logic [`TRACE_CAUSE_W-1:0] cause;
  } commit_entry_t;

  // one stamped trace record, 137 bits
  typedef struct packed {
    logic [`TRACE_STAMP_W-1:0] stamp;
    logic [`TRACE_XLEN-1:0]    pc;
    logic [`TRACE_TVAL_W-1:0]  tval;
    trace_mode_e               mode;
    logic                      is_exc;
    logic [`TRACE_CAUSE_W-1:0] cause;
  } trace_rec_t;

endpackage

// File: common/trace_macros.svh
// trace path sizing and cause codes, included by the package and by every module that sizes ports
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// commit ports sampled per cycle
`define TRACE_NR_COMMIT_PORTS 2

// record field widths
`define TRACE_XLEN    64
`define TRACE_TVAL_W  32
`define TRACE_CAUSE_W 6
`define TRACE_STAMP_W 32
`define TRACE_CNT_W   32

// buffer capacity in records, power of two
`define TRACE_FIFO_DEPTH 8

`define TRACE_CAUSE_ILLEGAL 2

`endif
